// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;
    localparam int BANKS    = 8;
    localparam int SETS     = 128;
    localparam int TAGV_W   = TAG_W + 1;  // valid on top
    localparam int LINE_W   = 256;

    // every mode invalidates both ways of the indexed set
    typedef enum logic [1:0] {
        CACOP_INIT    = 2'd0,
        CACOP_IDX_INV = 2'd1,
        CACOP_HIT_INV = 2'd2
    } cacop_mode_e;

    typedef struct packed {
        logic        en;
        cacop_mode_e mode;
        logic [31:0] addr;
    } cacop_req_t;

    // array view of an address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    // fetch view for bank select and line base
    typedef struct packed {
        logic [TAG_W+INDEX_W-1:0] line;
        logic [2:0]               word;
        logic [1:0]               byte_off;
    } fetch_addr_t;

    typedef union packed {
        cache_addr_t c;
        fetch_addr_t f;
    } icache_addr_u;

endpackage

`default_nettype wire

// File: fetch_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_out_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush_i,
    input  logic        branch_flush_i,
    input  req_q_t      req_q_i,
    input  logic        inst_ok_i,
    input  logic [31:0] inst_i,
    output fetch_resp_t fetch_o
);

    fetch_resp_t resp_q;

    always_ff @(posedge clk) begin
        if (reset || flush_i || branch_flush_i) begin
            resp_q <= '0;
        end else begin
            resp_q.valid <= inst_ok_i;
            resp_q.pc    <= req_q_i.pc;
            resp_q.inst  <= inst_i;
            resp_q.exc   <= req_q_i.exc;   // front-end exception rides along
            resp_q.ecode <= req_q_i.ecode;
        end
    end

    assign fetch_o = resp_q;

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // pipeline control from the backend
    typedef struct packed {
        logic [7:0] pause;
        logic       exception_flush;
    } ctrl_t;

    // request presented by the front end
    typedef struct packed {
        logic [31:0] pc;
        logic        valid;
        logic        uncache;
        logic        exc;
        logic [6:0]  ecode;
    } fetch_req_t;

    // response toward the instruction buffer
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        exc;
        logic [6:0]  ecode;
    } fetch_resp_t;

    // held request with a kill mark for pipeline flushes
    typedef struct packed {
        logic [31:0] pc;
        logic        valid;
        logic        uncache;
        logic        exc;
        logic [6:0]  ecode;
        logic        killed;
    } req_q_t;

    // flush coming from the backend control vector
    function automatic logic ctrl_flush(input ctrl_t ctrl);
        return ctrl.exception_flush || (ctrl.pause[1] && !ctrl.pause[2]);
    endfunction

endpackage

`default_nettype wire

// File: fetch_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_req_stage
    import fetch_pkg::*;
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  fetch_req_t         fetch_req_i,
    input  logic               stall_i,
    input  ctrl_t              ctrl_i,
    input  logic               branch_flush_i,
    output req_q_t             req_q_o,
    output logic [INDEX_W-1:0] rd_index_o
);

    req_q_t req_q;
    logic   pipe_flush;
    logic   load;

    assign pipe_flush = ctrl_flush(ctrl_i);
    assign load       = !stall_i && !ctrl_i.pause[0] && !pipe_flush;

    always_ff @(posedge clk) begin
        if (reset || branch_flush_i) begin
            req_q <= '0;
        end else if (pipe_flush) begin
            req_q.killed <= 1'b1;  // drop whatever is in flight
        end else if (load) begin
            req_q <= '{
                pc:      fetch_req_i.pc,
                valid:   fetch_req_i.valid,
                uncache: fetch_req_i.uncache,
                exc:     fetch_req_i.exc,
                ecode:   fetch_req_i.ecode,
                killed:  1'b0
            };
        end
    end

    // arrays read the next pc, or re-read the held one so that
    // their synchronous output keeps matching req_q
    always_comb begin
        if (load) begin
            rd_index_o = fetch_req_i.pc[OFFSET_W +: INDEX_W];
        end else begin
            rd_index_o = req_q.pc[OFFSET_W +: INDEX_W];
        end
    end

    assign req_q_o = req_q;

endmodule

`default_nettype wire

// File: icache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module icache_chk
    import fetch_pkg::*;
    import cache_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input ctrl_t       ctrl_i,
    input logic        branch_flush_i,
    input cacop_req_t  cacop_i,
    input logic        ret_valid_i,
    input logic        stall_i,
    input logic        rd_req_i,
    input logic [31:0] rd_addr_i,
    input logic        uc_ren_i,
    input fetch_resp_t fetch_i
);

    logic flush;
    int   fail_cnt = 0;

    assign flush = branch_flush_i || ctrl_i.exception_flush ||
                   (ctrl_i.pause[1] && !ctrl_i.pause[2]);

    a_reset_stall: assert property (@(posedge clk) reset |-> stall_i)
        else begin
            $error("stall_o low during reset");
            fail_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk)
        reset |=> !rd_req_i && !uc_ren_i && !fetch_i.valid)
        else begin
            $error("memory request or response right after reset");
            fail_cnt++;
        end

    // a flush always wins over the stall
    a_flush_go: assert property (@(posedge clk) disable iff (reset) flush |-> !stall_i)
        else begin
            $error("stall_o high in a flush cycle");
            fail_cnt++;
        end

    a_flush_kill: assert property (@(posedge clk) disable iff (reset)
        branch_flush_i |=> !fetch_i.valid)
        else begin
            $error("response valid after a branch flush");
            fail_cnt++;
        end

    a_one_port: assert property (@(posedge clk) disable iff (reset)
        !(rd_req_i && uc_ren_i))
        else begin
            $error("line and uncached requests at once");
            fail_cnt++;
        end

    // refill address stays on the held line
    a_rd_stable: assert property (@(posedge clk) disable iff (reset)
        rd_req_i |=> !rd_req_i || $stable(rd_addr_i))
        else begin
            $error("rd_addr_o changed while rd_req_o was held");
            fail_cnt++;
        end

    a_pending_stall: assert property (@(posedge clk) (rd_req_i || uc_ren_i) |-> stall_i)
        else begin
            $error("no stall while a memory request is pending");
            fail_cnt++;
        end

    // level held until the return, a flush or a cache op
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req_i && !ret_valid_i && !flush && !cacop_i.en
        |=> rd_req_i || flush || ret_valid_i || cacop_i.en)
        else begin
            $error("rd_req_o dropped before its return");
            fail_cnt++;
        end

endmodule

bind icache_top icache_chk icache_chk_i (
    .clk            (clk),
    .reset          (reset),
    .ctrl_i         (ctrl_i),
    .branch_flush_i (branch_flush_i),
    .cacop_i        (cacop_i),
    .ret_valid_i    (ret_valid_i),
    .stall_i        (stall_o),
    .rd_req_i       (rd_req_o),
    .rd_addr_i      (rd_addr_o),
    .uc_ren_i       (uc_ren_o),
    .fetch_i        (fetch_o)
);

`default_nettype wire

// File: icache_core.sv
`timescale 1ns/1ps
`default_nettype none

module icache_core
    import fetch_pkg::*;
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  req_q_t             req_q_i,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  cacop_req_t         cacop_i,
    input  logic               ret_ok_i,
    input  logic               uc_ok_i,
    input  logic [LINE_W-1:0]  ret_data_i,
    input  logic [31:0]        uc_rdata_i,
    output logic               miss_o,
    output logic               inst_ok_o,
    output logic [31:0]        inst_o,
    output logic               cacop_busy_o
);

    icache_addr_u           req_addr;
    icache_addr_u           cacop_addr;
    logic [BANKS-1:0][31:0] ret_words;
    logic [31:0]            bank_rdata [2][BANKS];
    logic [TAGV_W-1:0]      tagv_rdata [2];
    logic [1:0]             way_hit;
    logic [1:0]             refill_we;
    logic [1:0]             tagv_we;
    logic [INDEX_W-1:0]     tagv_waddr;
    logic [TAGV_W-1:0]      tagv_wdata;
    logic [SETS-1:0]        lru;       // set bit means way 1 is the victim
    logic                   lru_pick;
    logic                   live;
    logic                   cached;
    logic                   hit;
    logic                   refill_en;
    logic                   cacop_inv;
    logic                   cacop_busy;
    logic                   cacop_active;

    assign req_addr   = req_q_i.pc;
    assign cacop_addr = cacop_i.addr;
    assign ret_words  = ret_data_i;

    assign cacop_inv = cacop_i.en &&
                       (cacop_i.mode inside {CACOP_INIT, CACOP_IDX_INV, CACOP_HIT_INV});
    assign cacop_active = cacop_inv || cacop_busy;  // array output may be stale

    assign live   = req_q_i.valid && !req_q_i.killed;
    assign cached = live && !req_q_i.uncache;

    assign lru_pick  = lru[req_addr.c.index];
    assign refill_en = cached && ret_ok_i;

    // invalidation takes the tag port over a refill
    assign tagv_waddr = cacop_inv ? cacop_addr.c.index : req_addr.c.index;
    assign tagv_wdata = cacop_inv ? '0 : {1'b1, req_addr.c.tag};

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            icache_sdp_ram #(
                .WIDTH (32),
                .DEPTH (SETS)
            ) data_ram_i (
                .clk     (clk),
                .we_i    (refill_we[w]),
                .waddr_i (req_addr.c.index),
                .wdata_i (ret_words[b]),
                .raddr_i (rd_index_i),
                .rdata_o (bank_rdata[w][b])
            );
        end

        icache_sdp_ram #(
            .WIDTH (TAGV_W),
            .DEPTH (SETS)
        ) tagv_ram_i (
            .clk     (clk),
            .we_i    (tagv_we[w]),
            .waddr_i (tagv_waddr),
            .wdata_i (tagv_wdata),
            .raddr_i (rd_index_i),
            .rdata_o (tagv_rdata[w])
        );

        assign way_hit[w] = tagv_rdata[w][TAGV_W-1] &&
                            (tagv_rdata[w][TAG_W-1:0] == req_addr.c.tag);
        assign refill_we[w] = refill_en && (lru_pick == 1'(w));
        assign tagv_we[w]   = cacop_inv || refill_we[w];
    end

    assign hit    = cached && (|way_hit) && !cacop_active;
    assign miss_o = cached && !(|way_hit) && !cacop_active;

    always_comb begin
        inst_o = '0;
        if (uc_ok_i) begin
            inst_o = uc_rdata_i;
        end else if (way_hit[0]) begin
            inst_o = bank_rdata[0][req_addr.f.word];
        end else if (way_hit[1]) begin
            inst_o = bank_rdata[1][req_addr.f.word];
        end else if (ret_ok_i) begin
            inst_o = ret_words[req_addr.f.word];  // forwarded refill word
        end
    end

    assign inst_ok_o = (live && req_q_i.uncache && uc_ok_i) || hit || refill_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru        <= '0;
            cacop_busy <= 1'b0;
        end else begin
            if (refill_en) begin
                lru[req_addr.c.index] <= ~lru_pick;
            end else if (hit) begin
                lru[req_addr.c.index] <= way_hit[0];
            end
            cacop_busy <= cacop_inv;
        end
    end

    assign cacop_busy_o = cacop_busy;

endmodule

`default_nettype wire

// File: icache_fetch.f
fetch_pkg.sv
cache_pkg.sv
icache_sdp_ram.sv
fetch_req_stage.sv
icache_refill_ctrl.sv
icache_core.sv
fetch_out_stage.sv
icache_top.sv
icache_chk.sv
icache_tb.sv

// File: icache_refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl
    import fetch_pkg::*;
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  req_q_t      req_q_i,
    input  logic        miss_i,
    input  logic        flush_i,
    input  logic        ret_valid_i,
    input  logic        uc_rvalid_i,
    output logic        rd_req_o,
    output logic [31:0] rd_addr_o,
    output logic        uc_ren_o,
    output logic [31:0] uc_addr_o,
    output logic        ret_ok_o,
    output logic        uc_ok_o,
    output logic        busy_o
);

    icache_addr_u req_addr;
    logic         uc_need;
    logic         out_rd;   // line request seen by memory
    logic         out_uc;
    logic         ignore;   // next return belongs to a flushed request
    logic         done;     // held request was answered last cycle

    assign req_addr = req_q_i.pc;
    assign uc_need  = req_q_i.valid && !req_q_i.killed && req_q_i.uncache;

    assign ret_ok_o = ret_valid_i && !ignore;
    assign uc_ok_o  = uc_rvalid_i && !ignore;

    assign rd_req_o  = miss_i && !ignore && !done && !flush_i && !ret_ok_o;
    assign rd_addr_o = {req_addr.f.line, {OFFSET_W{1'b0}}};
    assign uc_ren_o  = uc_need && !ignore && !done && !flush_i && !uc_ok_o;
    assign uc_addr_o = req_q_i.pc;

    assign busy_o = (miss_i || uc_need) && !done;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_rd <= 1'b0;
            out_uc <= 1'b0;
            ignore <= 1'b0;
            done   <= 1'b0;
        end else begin
            if (ret_valid_i) begin
                out_rd <= 1'b0;
            end else if (rd_req_o) begin
                out_rd <= 1'b1;
            end
            if (uc_rvalid_i) begin
                out_uc <= 1'b0;
            end else if (uc_ren_o) begin
                out_uc <= 1'b1;
            end
            // a return in the flush cycle itself is already gone
            if (flush_i && (out_rd || out_uc) && !ret_valid_i && !uc_rvalid_i) begin
                ignore <= 1'b1;
            end else if (ret_valid_i || uc_rvalid_i) begin
                ignore <= 1'b0;
            end
            done <= ret_ok_o || uc_ok_o;
        end
    end

endmodule

`default_nettype wire

// File: icache_sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_sdp_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [WIDTH-1:0]         rdata_o
);

    // zero start so tag valid bits come up clear
    logic [WIDTH-1:0] mem [DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];  // old data on a same-address write
    end

endmodule

`default_nettype wire

// File: icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import fetch_pkg::*;
    import cache_pkg::*;
();

    localparam int N_REQ        = 22;
    localparam int LIMIT_CYCLES = N_REQ * 12 + 100;

    typedef struct packed {
        fetch_resp_t resp;
        logic        saw_rd;
        logic        saw_uc;
        logic [7:0]  lat;    // negedges since acceptance
        logic [7:0]  rd_at;
    } fetch_res_t;

    logic              clk = 1'b0;
    logic              reset;
    fetch_req_t        fetch_req_i;
    ctrl_t             ctrl_i;
    logic              branch_flush_i;
    cacop_req_t        cacop_i;
    logic              ret_valid_i;
    logic [LINE_W-1:0] ret_data_i;
    logic              uc_rvalid_i;
    logic [31:0]       uc_rdata_i;
    logic              stall_o;
    logic              rd_req_o;
    logic [31:0]       rd_addr_o;
    logic              uc_ren_o;
    logic [31:0]       uc_addr_o;
    fetch_resp_t       fetch_o;

    logic [31:0] rng = 32'hef6ba1ab;
    int          errors = 0;
    int          checks = 0;
    int          test_base = 0;
    logic        kill_watch = 1'b0;
    logic [31:0] kill_pc = '0;

    icache_top icache_top_i (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // word k of a line is base + 4k xor a fixed mask
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] line_base(input logic [31:0] pc);
        icache_addr_u a;
        a          = pc;
        a.c.offset = '0;
        return a;
    endfunction

    function automatic fetch_req_t mk_req(input logic [31:0] pc, input logic unc);
        fetch_req_t r;
        r         = '0;
        r.pc      = pc;
        r.valid   = 1'b1;
        r.uncache = unc;
        return r;
    endfunction

    function automatic int error_total();
        return errors + icache_top_i.icache_chk_i.fail_cnt;
    endfunction

    task automatic check_val(input string name, input logic [31:0] want, input logic [31:0] got);
        checks++;
        assert (got === want) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, want, got);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            $display("failure: %s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        int n;
        n = error_total() - test_base;
        $display("test %-12s %s, %0d error(s)", name, (n == 0) ? "pass" : "FAIL", n);
        test_base = error_total();
    endtask

    // hold the request until the request stage takes it
    task automatic present(input fetch_req_t req);
        @(posedge clk);
        fetch_req_i <= req;
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        fetch_req_i.valid <= 1'b0;
    endtask

    task automatic fetch(input string name, input fetch_req_t req, output fetch_res_t res);
        res = '0;
        present(req);
        do begin
            @(negedge clk);
            res.lat = res.lat + 8'd1;
            if (rd_req_o && !res.saw_rd) begin
                res.saw_rd = 1'b1;
                res.rd_at  = res.lat;
                check_val({name, " rd_addr"}, line_base(req.pc), rd_addr_o);
            end
            if (uc_ren_o && !res.saw_uc) begin
                res.saw_uc = 1'b1;
                check_val({name, " uc_addr"}, req.pc, uc_addr_o);
            end
        end while (!fetch_o.valid && res.lat < 8'd40);
        check_true("a fetch got no response", fetch_o.valid);
        res.resp = fetch_o;
    endtask

    task automatic expect_fetch(input string name, input fetch_req_t req, input logic miss,
                                output fetch_res_t res);
        fetch(name, req, res);
        check_val({name, " pc"}, req.pc, res.resp.pc);
        check_val({name, " inst"}, req.uncache ? ~req.pc : mem_word(req.pc), res.resp.inst);
        check_val({name, " refill"}, 32'(miss), 32'(res.saw_rd));
        check_val({name, " uncached"}, 32'(req.uncache), 32'(res.saw_uc));
        check_val({name, " exc"}, 32'(req.exc), 32'(res.resp.exc));
        check_val({name, " ecode"}, 32'(req.ecode), 32'(res.resp.ecode));
    endtask

    task automatic cache_op(input cacop_mode_e mode, input logic [31:0] addr);
        @(posedge clk);
        cacop_i <= '{en: 1'b1, mode: mode, addr: addr};
        @(posedge clk);
        cacop_i.en <= 1'b0;
    endtask

    // line memory, one refill outstanding
    initial begin
        logic [LINE_W-1:0] line;
        logic [31:0]       base;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        forever begin
            @(negedge clk);
            if (rd_req_o) begin
                base = rd_addr_o;
                for (int k = 0; k < BANKS; k++) begin
                    line[k*32 +: 32] = mem_word(base + 32'(4 * k));
                end
                rng = xorshift(rng);
                repeat (2 + rng % 5) @(posedge clk);
                ret_valid_i <= 1'b1;
                ret_data_i  <= line;
                @(posedge clk);
                ret_valid_i <= 1'b0;
            end
        end
    end

    // uncached port answers with the inverted address
    initial begin
        logic [31:0] addr;
        uc_rvalid_i = 1'b0;
        uc_rdata_i  = '0;
        forever begin
            @(negedge clk);
            if (uc_ren_o) begin
                addr = uc_addr_o;
                rng  = xorshift(rng);
                repeat (2 + rng % 3) @(posedge clk);
                uc_rvalid_i <= 1'b1;
                uc_rdata_i  <= ~addr;
                @(posedge clk);
                uc_rvalid_i <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (kill_watch) begin
            assert (!(fetch_o.valid && fetch_o.pc == kill_pc)) else begin
                $display("failure: a response came back for the flushed pc %h", kill_pc);
                errors++;
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        fetch_res_t res;
        fetch_req_t req;
        int         n;
        reset          = 1'b1;
        fetch_req_i    = '0;
        ctrl_i         = '0;
        branch_flush_i = 1'b0;
        cacop_i        = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_true("stall_o low during reset", stall_o);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_true("ports busy after reset", !rd_req_o && !uc_ren_o && !fetch_o.valid);
        report_test("reset");

        expect_fetch("first miss", mk_req(32'h0000_1234, 1'b0), 1'b1, res);
        check_val("rd_req cycle", 32'd1, 32'(res.rd_at));
        expect_fetch("hit", mk_req(32'h0000_1234, 1'b0), 1'b0, res);
        check_val("hit latency", 32'd2, 32'(res.lat));
        expect_fetch("hit word 0", mk_req(32'h0000_1220, 1'b0), 1'b0, res);
        check_val("hit latency", 32'd2, 32'(res.lat));
        report_test("miss_hit");

        // three lines in set 5
        expect_fetch("A fill", mk_req(32'h0010_00a4, 1'b0), 1'b1, res);
        expect_fetch("B fill", mk_req(32'h0020_00a8, 1'b0), 1'b1, res);
        expect_fetch("A hit", mk_req(32'h0010_00ac, 1'b0), 1'b0, res);
        expect_fetch("C fill", mk_req(32'h0030_00b0, 1'b0), 1'b1, res);
        expect_fetch("A kept", mk_req(32'h0010_00a0, 1'b0), 1'b0, res);
        expect_fetch("C kept", mk_req(32'h0030_00bc, 1'b0), 1'b0, res);
        expect_fetch("B evicted", mk_req(32'h0020_00a8, 1'b0), 1'b1, res);
        report_test("replace");

        expect_fetch("uncached", mk_req(32'h1fc0_0010, 1'b1), 1'b0, res);
        expect_fetch("uncached again", mk_req(32'h1fc0_0010, 1'b1), 1'b0, res);
        report_test("uncached");

        expect_fetch("inv fill", mk_req(32'h0004_0660, 1'b0), 1'b1, res);
        for (int m = 0; m < 3; m++) begin
            cache_op(cacop_mode_e'(m), 32'h0004_0668);
            expect_fetch("after cacop", mk_req(32'h0004_0664, 1'b0), 1'b1, res);
        end
        expect_fetch("inv refilled", mk_req(32'h0004_0660, 1'b0), 1'b0, res);
        report_test("invalidate");

        kill_pc = 32'h0005_0800;
        present(mk_req(kill_pc, 1'b0));
        kill_watch = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rd_req_o && n < 20);
        check_true("the killed fetch raised no refill request", rd_req_o);
        @(posedge clk);
        branch_flush_i <= 1'b1;
        @(posedge clk);
        branch_flush_i <= 1'b0;
        expect_fetch("after flush", mk_req(32'h0006_0c08, 1'b0), 1'b1, res);
        kill_watch = 1'b0;
        expect_fetch("flushed line", mk_req(kill_pc, 1'b0), 1'b1, res);
        report_test("flush");

        req       = mk_req(32'h0000_1238, 1'b0);
        req.exc   = 1'b1;
        req.ecode = 7'h15;
        expect_fetch("exc hit", req, 1'b0, res);
        req       = mk_req(32'h1fc0_0020, 1'b1);
        req.exc   = 1'b1;
        req.ecode = 7'h2a;
        expect_fetch("exc uncached", req, 1'b0, res);
        report_test("exception");

        $display("summary: %0d checks, %0d testbench errors, %0d assertion failures",
                 checks, errors, icache_top_i.icache_chk_i.fail_cnt);
        if (error_total() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import fetch_pkg::*;
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  fetch_req_t        fetch_req_i,
    input  ctrl_t             ctrl_i,
    input  logic              branch_flush_i,
    input  cacop_req_t        cacop_i,
    input  logic              ret_valid_i,
    input  logic [LINE_W-1:0] ret_data_i,
    input  logic              uc_rvalid_i,
    input  logic [31:0]       uc_rdata_i,
    output logic              stall_o,
    output logic              rd_req_o,
    output logic [31:0]       rd_addr_o,
    output logic              uc_ren_o,
    output logic [31:0]       uc_addr_o,
    output fetch_resp_t       fetch_o
);

    req_q_t             req_q;
    logic [INDEX_W-1:0] rd_index;
    logic               pipe_flush;
    logic               flush;
    logic               miss;
    logic               ret_ok;
    logic               uc_ok;
    logic               refill_busy;
    logic               inst_ok;
    logic [31:0]        inst;
    logic               cacop_busy;

    assign pipe_flush = ctrl_flush(ctrl_i);
    assign flush      = branch_flush_i || pipe_flush;

    // flush wins over every stall source
    assign stall_o = reset ? 1'b1 :
                     flush ? 1'b0 :
                     (cacop_i.en || cacop_busy || refill_busy);

    fetch_req_stage fetch_req_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fetch_req_i    (fetch_req_i),
        .stall_i        (stall_o),
        .ctrl_i         (ctrl_i),
        .branch_flush_i (branch_flush_i),
        .req_q_o        (req_q),
        .rd_index_o     (rd_index)
    );

    icache_refill_ctrl icache_refill_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .req_q_i     (req_q),
        .miss_i      (miss),
        .flush_i     (flush),
        .ret_valid_i (ret_valid_i),
        .uc_rvalid_i (uc_rvalid_i),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .uc_ren_o    (uc_ren_o),
        .uc_addr_o   (uc_addr_o),
        .ret_ok_o    (ret_ok),
        .uc_ok_o     (uc_ok),
        .busy_o      (refill_busy)
    );

    icache_core icache_core_i (
        .clk          (clk),
        .reset        (reset),
        .req_q_i      (req_q),
        .rd_index_i   (rd_index),
        .cacop_i      (cacop_i),
        .ret_ok_i     (ret_ok),
        .uc_ok_i      (uc_ok),
        .ret_data_i   (ret_data_i),
        .uc_rdata_i   (uc_rdata_i),
        .miss_o       (miss),
        .inst_ok_o    (inst_ok),
        .inst_o       (inst),
        .cacop_busy_o (cacop_busy)
    );

    fetch_out_stage fetch_out_stage_i (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (pipe_flush),
        .branch_flush_i (branch_flush_i),
        .req_q_i        (req_q),
        .inst_ok_i      (inst_ok),
        .inst_i         (inst),
        .fetch_o        (fetch_o)
    );

endmodule

`default_nettype wire
